/* verilog/antic_cfg.svh */
// Register offsets, control bit positions and address width
`ifndef ANTIC_CFG_SVH
`define ANTIC_CFG_SVH

// CPU register offsets
`define REG_DMACTL      4'd0
`define REG_DLISTL      4'd2
`define REG_DLISTH      4'd3
`define REG_NMIEN       4'd14
`define REG_NMIRES      4'd15   // Write side
`define REG_NMIST       4'd15   // Read side, same offset

// Display-list DMA enable in DMACTL
`define DMACTL_DL_BIT   5

// Interrupt enables in NMIEN
`define NMIEN_DLI_BIT   7
`define NMIEN_VBI_BIT   6

// Memory address width
`define ADDR_W          16

`endif

/* verilog/anticPkg.sv */
// Display-list instruction views, instruction class and fetch FSM states
package anticPkg;

        // Mode line layout
        typedef struct packed {
                logic       dli;
                logic       lms;        // Load memory scan
                logic       vscrol;
                logic       hscrol;
                logic [3:0] mode;
        } modeFields;

        // Blank line and jump layout
        // Bit 6 is the JVB flag for jumps and the top count bit for blank lines
        typedef struct packed {
                logic       dli;
                logic       jvb;
                logic [1:0] count;
                logic [3:0] kind;       // 0 blank, 1 jump
        } blankFields;

        typedef union packed {
                modeFields  modeView;
                blankFields blankView;
        } dlInstr;

        typedef enum logic [1:0] {
                blankLine,
                jump,
                modeLine
        } instrClass;

        // Each byte takes a request cycle and a capture cycle
        typedef enum logic [2:0] {
                idle,
                opcodeReq,
                opcodeCap,
                lowReq,
                lowCap,
                highReq,
                highCap,
                waitVblank
        } fetchState;

endpackage

/* verilog/anticRegs.sv */
// CPU register file: DMACTL, display-list pointer, NMIEN and NMI status
`include "antic_cfg.svh"

module anticRegs (
        input  logic               phi2,
        input  logic               RST,
        input  logic               regWrite,
        input  logic [3:0]         regAddr,
        input  logic [7:0]         regData,
        input  logic               regRead,
        input  logic               dliEvent,
        input  logic               vbiEvent,
        output logic [7:0]         readData,
        output logic               dlEnable,
        output logic [1:0]         nmienBits,
        output logic               ptrLoad,
        output logic [`ADDR_W-1:0] ptrValue
);
        logic       dmactlDl;
        logic [7:0] dlistL;
        logic [7:0] dlistH;
        logic [1:0] nmien;      // {DLI, VBI}
        logic       dliStatus;
        logic       vbiStatus;
        logic       nmiresWrite;

        assign nmiresWrite = regWrite && (regAddr == `REG_NMIRES);

        always_ff @(posedge phi2) begin
                if (RST) begin
                        dmactlDl  <= 1'b0;
                        dlistL    <= 8'd0;
                        dlistH    <= 8'd0;
                        nmien     <= 2'b00;
                        dliStatus <= 1'b0;
                        vbiStatus <= 1'b0;
                        ptrLoad   <= 1'b0;
                        readData  <= 8'd0;
                end else begin
                        ptrLoad <= 1'b0;
                        if (regWrite) begin
                                case (regAddr)
                                `REG_DMACTL: dmactlDl <= regData[`DMACTL_DL_BIT];
                                `REG_DLISTL: dlistL <= regData;
                                `REG_DLISTH: begin
                                        dlistH  <= regData;
                                        ptrLoad <= 1'b1;        // Pointer reloads next cycle
                                end
                                `REG_NMIEN: nmien <= {regData[`NMIEN_DLI_BIT],
                                                      regData[`NMIEN_VBI_BIT]};
                                default: ;
                                endcase
                        end

                        // A new event beats a same-cycle NMIRES
                        if (dliEvent)
                                dliStatus <= 1'b1;
                        else if (nmiresWrite)
                                dliStatus <= 1'b0;
                        if (vbiEvent)
                                vbiStatus <= 1'b1;
                        else if (nmiresWrite)
                                vbiStatus <= 1'b0;

                        if (regRead)
                                readData <= (regAddr == `REG_NMIST) ?
                                            {dliStatus, vbiStatus, 6'd0} : 8'd0;
                end
        end

        assign dlEnable  = dmactlDl;
        assign nmienBits = nmien;
        assign ptrValue  = {dlistH, dlistL};    // New DLISTH with stored DLISTL

endmodule

/* verilog/instrDecode.sv */
// Instruction decode, current mode, vertical blank flag and NMI generation
module instrDecode (
        input  logic                 phi2,
        input  logic                 RST,
        input  logic                 instrCapture,
        input  logic [7:0]           capturedByte,
        input  logic                 instrDone,
        input  logic                 enterVblank,
        input  logic                 frameStart,
        input  logic [1:0]           nmienBits,
        output anticPkg::instrClass  instClass,
        output logic                 needsOperands,
        output logic                 jvb,
        output logic [2:0]           AN,
        output logic                 nmiL,
        output logic                 dliEvent,
        output logic                 vbiEvent,
        output logic                 vblank
);
        import anticPkg::*;

        logic [7:0] heldByte;
        dlInstr     curInstr;
        logic [3:0] curMode;
        logic       vbiStart;

        // Decode the byte being captured, then the held copy while operands load
        assign curInstr = instrCapture ? capturedByte : heldByte;

        always_comb begin
                case (curInstr.blankView.kind)
                4'd0:    instClass = blankLine;
                4'd1:    instClass = jump;
                default: instClass = modeLine;
                endcase
        end

        assign needsOperands = (instClass == jump) ||
                               ((instClass == modeLine) && curInstr.modeView.lms);
        assign jvb      = (instClass == jump) && curInstr.blankView.jvb;
        assign vbiStart = frameStart && vblank;         // End of JVB wait
        assign AN       = curMode[2:0];

        always_ff @(posedge phi2) begin
                if (instrCapture)
                        heldByte <= capturedByte;
        end

        always_ff @(posedge phi2) begin
                if (RST) begin
                        curMode  <= 4'd0;
                        vblank   <= 1'b0;
                        dliEvent <= 1'b0;
                        vbiEvent <= 1'b0;
                        nmiL     <= 1'b1;
                end else begin
                        if (instrDone && (instClass == modeLine))
                                curMode <= curInstr.modeView.mode;

                        if (enterVblank)
                                vblank <= 1'b1;
                        else if (frameStart)
                                vblank <= 1'b0;

                        // Status events are not gated by NMIEN
                        dliEvent <= instrDone && curInstr.modeView.dli;
                        vbiEvent <= vbiStart;

                        // DLI lands the cycle after instrValid
                        nmiL <= !((dliEvent && nmienBits[1]) ||
                                  (vbiStart && nmienBits[0]));
                end
        end

endmodule

/* verilog/dlistFetch.sv */
// Display-list fetch FSM, pointer counter and memory scan address
`include "antic_cfg.svh"

module dlistFetch (
        input  logic                 phi2,
        input  logic                 RST,
        input  logic                 dlEnable,
        input  logic                 ptrLoad,
        input  logic [`ADDR_W-1:0]   ptrValue,
        input  logic                 lineDone,
        input  logic                 frameStart,
        input  logic [7:0]           memData,
        input  anticPkg::instrClass  instClass,
        input  logic                 needsOperands,
        input  logic                 jvb,
        output logic                 dmaReq,
        output logic [`ADDR_W-1:0]   address,
        output logic                 instrCapture,
        output logic [7:0]           capturedByte,
        output logic                 instrDone,
        output logic                 enterVblank,
        output logic                 instrValid,
        output logic [7:0]           instrByte,
        output logic [`ADDR_W-1:0]   scanAddr
);
        import anticPkg::*;

        fetchState          state;
        fetchState          nextState;
        logic [`ADDR_W-1:0] dlPtr;
        logic [7:0]         opcode;
        logic [7:0]         lowByte;
        logic [7:0]         reportByte;
        logic [`ADDR_W-1:0] operandAddr;
        logic               isJump;

        assign isJump      = (instClass == jump);
        assign operandAddr = {memData, lowByte};        // Low byte first in memory
        assign reportByte  = (state == opcodeCap) ? memData : opcode;

        // Memory side
        assign dmaReq  = state inside {opcodeReq, lowReq, highReq};
        assign address = dlPtr;

        // Strobes to the decoder
        assign instrCapture = (state == opcodeCap);
        assign capturedByte = memData;
        assign instrDone    = (instrCapture && !needsOperands) || (state == highCap);
        assign enterVblank  = (state == highCap) && isJump && jvb;

        always_comb begin
                nextState = state;
                case (state)
                idle: begin
                        if (lineDone && dlEnable)
                                nextState = opcodeReq;
                end
                opcodeReq: nextState = opcodeCap;
                opcodeCap: nextState = needsOperands ? lowReq : idle;
                lowReq:    nextState = lowCap;
                lowCap:    nextState = highReq;
                highReq:   nextState = highCap;
                highCap:   nextState = enterVblank ? waitVblank : idle;
                waitVblank: begin
                        if (frameStart)
                                nextState = idle;
                end
                default:   nextState = idle;
                endcase
        end

        always_ff @(posedge phi2) begin
                if (RST) begin
                        state      <= idle;
                        dlPtr      <= '0;
                        scanAddr   <= '0;
                        instrValid <= 1'b0;
                end else begin
                        state      <= nextState;
                        instrValid <= instrDone;

                        // CPU load overrides whatever the FSM is doing
                        if (ptrLoad)
                                dlPtr <= ptrValue;
                        else if ((state == highCap) && isJump)
                                dlPtr <= operandAddr;
                        else if (state inside {opcodeCap, lowCap, highCap})
                                dlPtr <= dlPtr + 1'b1;

                        // Only an LMS mode line gets here without being a jump
                        if ((state == highCap) && !isJump)
                                scanAddr <= operandAddr;
                end
        end

        always_ff @(posedge phi2) begin
                if (instrCapture)
                        opcode <= memData;
                if (state == lowCap)
                        lowByte <= memData;
                if (instrDone)
                        instrByte <= reportByte;        // Goes out with instrValid
        end

endmodule

/* verilog/anticTop.sv */
// Display-list DMA front end: register file, fetcher and decoder
`include "antic_cfg.svh"

module anticTop (
        input  logic               phi2,
        input  logic               RST,
        input  logic               regWrite,
        input  logic [3:0]         regAddr,
        input  logic [7:0]         regData,
        input  logic               regRead,
        output logic [7:0]         readData,
        input  logic [7:0]         memData,
        output logic               dmaReq,
        output logic [`ADDR_W-1:0] address,
        input  logic               lineDone,
        input  logic               frameStart,
        output logic               instrValid,
        output logic [7:0]         instrByte,
        output logic [`ADDR_W-1:0] scanAddr,
        output logic [2:0]         AN,
        output logic               nmiL,
        output logic               vblank
);
        import anticPkg::*;

        logic               dlEnable;
        logic [1:0]         nmienBits;
        logic               ptrLoad;
        logic [`ADDR_W-1:0] ptrValue;
        logic               dliEvent;
        logic               vbiEvent;
        logic               instrCapture;
        logic [7:0]         capturedByte;
        logic               instrDone;
        logic               enterVblank;
        instrClass          instClass;
        logic               needsOperands;
        logic               jvb;

        anticRegs i_anticRegs (
                .phi2      (phi2),
                .RST       (RST),
                .regWrite  (regWrite),
                .regAddr   (regAddr),
                .regData   (regData),
                .regRead   (regRead),
                .dliEvent  (dliEvent),
                .vbiEvent  (vbiEvent),
                .readData  (readData),
                .dlEnable  (dlEnable),
                .nmienBits (nmienBits),
                .ptrLoad   (ptrLoad),
                .ptrValue  (ptrValue)
        );

        instrDecode i_instrDecode (
                .phi2          (phi2),
                .RST           (RST),
                .instrCapture  (instrCapture),
                .capturedByte  (capturedByte),
                .instrDone     (instrDone),
                .enterVblank   (enterVblank),
                .frameStart    (frameStart),
                .nmienBits     (nmienBits),
                .instClass     (instClass),
                .needsOperands (needsOperands),
                .jvb           (jvb),
                .AN            (AN),
                .nmiL          (nmiL),
                .dliEvent      (dliEvent),
                .vbiEvent      (vbiEvent),
                .vblank        (vblank)
        );

        dlistFetch i_dlistFetch (
                .phi2          (phi2),
                .RST           (RST),
                .dlEnable      (dlEnable),
                .ptrLoad       (ptrLoad),
                .ptrValue      (ptrValue),
                .lineDone      (lineDone),
                .frameStart    (frameStart),
                .memData       (memData),
                .instClass     (instClass),
                .needsOperands (needsOperands),
                .jvb           (jvb),
                .dmaReq        (dmaReq),
                .address       (address),
                .instrCapture  (instrCapture),
                .capturedByte  (capturedByte),
                .instrDone     (instrDone),
                .enterVblank   (enterVblank),
                .instrValid    (instrValid),
                .instrByte     (instrByte),
                .scanAddr      (scanAddr)
        );

endmodule

/* dv/tbAntic.sv */
// Testbench for the display-list DMA front end with clock, reset and memory model
// Stimulus file reader, value check task and cycle timeout
`include "antic_cfg.svh"

module tbAntic;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int MAX_RECS     = 128;
        localparam int WATCH_CYCLES = 8;        // How long an ignored lineDone is watched

        logic        phi2;
        logic        RST;
        logic        regWrite;
        logic [3:0]  regAddr;
        logic [7:0]  regData;
        logic        regRead;
        logic [7:0]  readData;
        logic [7:0]  memData = 8'h00;
        logic        dmaReq;
        logic [15:0] address;
        logic        lineDone;
        logic        frameStart;
        logic        instrValid;
        logic [7:0]  instrByte;
        logic [15:0] scanAddr;
        logic [2:0]  AN;
        logic        nmiL;
        logic        vblank;

        logic [7:0]  mem [0:65535];
        int          recKind [0:MAX_RECS-1];
        logic [79:0] recData [0:MAX_RECS-1];    // Up to five hex fields
        int          recCount;
        int          cycleLimit;
        logic [15:0] expPtr;                    // Where the next opcode should be read
        logic [7:0]  expDlistL;

        anticTop i_anticTop (.*);

        initial begin
                phi2 = 1'b0;
                forever #20 phi2 = ~phi2;
        end

        // Read data appears on the falling edge of the request cycle
        always @(negedge phi2) begin
                if (dmaReq)
                        memData <= mem[address];
        end

        task automatic abortRun(input string why);
                $display("%s", why);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Run aborted");
        endtask

        task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                                  input string what);
                if (actual !== expected) begin
                        $display("MISMATCH at %0t: %s is %h, expected %h",
                                 $time, what, actual, expected);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "Value check failed");
                end
        endtask

        // Two cycles per byte, jumps and LMS mode lines carry two operand bytes
        function automatic int fetchCycles(input logic [7:0] op);
                if ((op[3:0] == 4'd1) || ((op[3:0] != 4'd0) && op[6]))
                        return 6;
                return 2;
        endfunction

        task automatic loadStimulus();
                int               fd;
                int               ch;
                int               n;
                logic [15:0]      a, b, c, d, e;
                logic [8*128-1:0] skipLine;
                fd = $fopen("dv/antic_stimulus.txt", "r");
                if (fd == 0)
                        abortRun("Cannot open the stimulus file dv/antic_stimulus.txt");
                recCount = 0;
                while ($fscanf(fd, " %c", ch) == 1) begin
                        {a, b, c, d, e} = 80'd0;
                        case (ch)
                        "#":           n = $fgets(skipLine, fd);
                        "M", "W", "R": n = $fscanf(fd, "%h %h", a, b);
                        "L":           n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                        "F", "Q":      n = $fscanf(fd, "%h", a);
                        default: abortRun($sformatf("Unknown stimulus record type %c", ch));
                        endcase
                        if (n < 1)
                                abortRun("Stimulus record is missing its fields");
                        if (ch == "M")
                                mem[a] = b[7:0];        // Placed before reset ends
                        else if (ch != "#") begin
                                recKind[recCount] = ch;
                                recData[recCount] = {a, b, c, d, e};
                                recCount++;
                        end
                end
                $fclose(fd);
        endtask

        task automatic runRecord(input int kind, input logic [79:0] fields);
                logic [15:0] a, b, c, d, e;
                int          waited;
                int          reqCount;
                int          expBytes;
                {a, b, c, d, e} = fields;
                waited = 0;
                reqCount = 0;
                @(negedge phi2);
                case (kind)
                "W", "R": begin
                        regAddr  = a[3:0];
                        regData  = b[7:0];
                        regWrite = (kind == "W");
                        regRead  = (kind == "R");
                        @(negedge phi2);
                        regWrite = 1'b0;
                        regRead  = 1'b0;
                        if (kind == "R")
                                checkValue(readData, b, "NMIST read");
                        if (kind == "W") begin
                                // DLISTH write loads the pointer with the stored DLISTL
                                if (a[3:0] == `REG_DLISTL)
                                        expDlistL = b[7:0];
                                else if (a[3:0] == `REG_DLISTH)
                                        expPtr = {b[7:0], expDlistL};
                        end
                end
                "L": begin
                        lineDone = 1'b1;
                        if (a == 16'd0) begin
                                repeat (WATCH_CYCLES) begin
                                        @(negedge phi2);
                                        lineDone = 1'b0;
                                        checkValue(dmaReq, 16'd0, "dmaReq on ignored line");
                                        checkValue(instrValid, 16'd0, "instrValid on ignored line");
                                        checkValue(nmiL, 16'd1, "nmiL on ignored line");
                                end
                        end else begin
                                expBytes = fetchCycles(b[7:0]) / 2;
                                do begin
                                        @(negedge phi2);
                                        lineDone = 1'b0;
                                        waited++;
                                        if (dmaReq) begin
                                                checkValue(address, expPtr + reqCount,
                                                           "DMA address");
                                                reqCount++;
                                        end
                                end while (!instrValid);
                                // Rising edges from the lineDone sample to instrValid
                                checkValue(waited - 1, fetchCycles(b[7:0]), "fetch latency");
                                checkValue(reqCount, expBytes, "DMA request count");
                                checkValue(instrByte, b, "instrByte");
                                checkValue(scanAddr, c, "scanAddr");
                                checkValue(AN, d, "AN");
                                @(negedge phi2);
                                checkValue(nmiL, !e[0], "nmiL after instrValid");
                                // Jumps continue at their operand, low byte first
                                if (b[3:0] == 4'd1)
                                        expPtr = {mem[expPtr + 16'd2], mem[expPtr + 16'd1]};
                                else
                                        expPtr = expPtr + expBytes[15:0];
                        end
                end
                "F": begin
                        checkValue(vblank, 16'd1, "vblank before frameStart");
                        frameStart = 1'b1;
                        @(negedge phi2);
                        frameStart = 1'b0;
                        checkValue(vblank, 16'd0, "vblank after frameStart");
                        checkValue(nmiL, !a[0], "nmiL after frameStart");
                end
                "Q": begin
                        repeat (a) begin
                                checkValue(dmaReq, 16'd0, "dmaReq in quiet cycle");
                                checkValue(instrValid, 16'd0, "instrValid in quiet cycle");
                                @(negedge phi2);
                        end
                end
                default: ;
                endcase
        endtask

        initial begin : watchdog
                int cycles;
                cycles = 0;
                wait (cycleLimit != 0);
                while (cycles < cycleLimit) begin
                        @(posedge phi2);
                        cycles++;
                end
                abortRun($sformatf("Timeout after %0d cycles without the run finishing",
                                   cycles));
        end

        initial begin : mainSequence
                int i;
                RST        = 1'b1;
                regWrite   = 1'b0;
                regRead    = 1'b0;
                regAddr    = 4'd0;
                regData    = 8'd0;
                lineDone   = 1'b0;
                frameStart = 1'b0;
                expPtr     = 16'd0;
                expDlistL  = 8'd0;
                for (i = 0; i < 65536; i++)
                        mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;     // Whole-address fill
                loadStimulus();
                cycleLimit = 20 * recCount + 100;
                repeat (16) @(negedge phi2);
                RST = 1'b0;
                for (i = 0; i < recCount; i++)
                        runRecord(recKind[i], recData[i]);
                @(negedge phi2);
                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

/* files.f */
+incdir+verilog
verilog/anticPkg.sv
verilog/anticRegs.sv
verilog/instrDecode.sv
verilog/dlistFetch.sv
verilog/anticTop.sv
dv/tbAntic.sv

/* dv/antic_stimulus.txt */
# M addr byte | W reg data | R reg expected | F vbiNmi | Q cycles
# L expect byte scanAddr AN nmi (expect 0 means no fetch), all values hex
M 2000 70
M 2001 42
M 2002 00
M 2003 40
M 2004 8F
M 2005 01
M 2006 00
M 2007 21
M 2100 84
M 2101 4E
M 2102 00
M 2103 50
M 2104 41
M 2105 00
M 2106 20
L 0 00 0000 0 0
R f 00
W 3 20
W 0 20
Q 3
L 1 70 0000 0 0
L 1 42 4000 2 0
L 1 8F 4000 7 0
R f 80
W f 00
L 1 01 4000 7 0
W e 80
L 1 84 4000 4 1
L 1 4E 5000 6 0
L 1 41 5000 6 0
L 0 00 0000 0 0
F 0
R f C0
W f 00
R f 00
W 2 04
W 3 21
W e 40
L 1 41 5000 6 0
Q 3
F 1
L 1 70 5000 6 0
R f 40
